// File: hw/sram_share_pkg.sv
package sram_share_pkg;

    //////////////////////////////////////////////////////////////////////
    // Slot sequencer round
    //////////////////////////////////////////////////////////////////////

    // One access slot per port, address phase then transfer phase
    typedef enum logic [1:0] {
        ACCESS_1 = 2'd0,
        XFER_1   = 2'd1,
        ACCESS_2 = 2'd2,
        XFER_2   = 2'd3
    } slot_state_t;

    // Clocks for one full pass through both slots
    localparam int ROUND_CYCLES = 4;

    //////////////////////////////////////////////////////////////////////
    // External SRAM geometry, 1K x 8
    //////////////////////////////////////////////////////////////////////

    localparam int ADDR_W_DEF = 10;
    localparam int DATA_W_DEF = 8;

endpackage

// File: hw/sram_port_mux.sv
`timescale 1ns/1ps

module sram_port_mux
    import sram_share_pkg::*;
#(
    parameter int ADDR_W = ADDR_W_DEF,
    parameter int DATA_W = DATA_W_DEF
) (
    input  logic              clk,
    input  logic              arst_n,
    // Port 1, host CPU, read or write
    input  logic [ADDR_W-1:0] a1,
    input  logic              we1_n,
    input  logic [DATA_W-1:0] din1,
    output logic [DATA_W-1:0] dout1,
    output logic              done1,
    // Port 2, scan reader, read only
    input  logic [ADDR_W-1:0] a2,
    output logic [DATA_W-1:0] dout2,
    output logic              done2,
    // SRAM pins
    output logic [ADDR_W-1:0] sram_a,
    input  logic [DATA_W-1:0] sram_d_in,
    output logic [DATA_W-1:0] sram_d_out,
    output logic              sram_d_oe,
    output logic              sram_ce_n,
    output logic              sram_oe_n,
    output logic              sram_we_n
);

    slot_state_t state;
    slot_state_t next_state;
    logic        wr1_q;

    //////////////////////////////////////////////////////////////////////
    // Round sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ACCESS_1;
            wr1_q <= 1'b0;
        end else begin
            state <= next_state;
            // Port 1 direction is fixed at the address phase
            if (state == ACCESS_1) begin
                wr1_q <= ~we1_n;
            end
        end
    end

    always_comb begin
        next_state = ACCESS_1;
        sram_a     = a1;
        sram_oe_n  = 1'b0;
        sram_we_n  = 1'b1;
        sram_d_oe  = 1'b0;
        case (state)
            ACCESS_1: begin
                // SRAM outputs already off ahead of a write
                sram_oe_n  = ~we1_n;
                next_state = XFER_1;
            end
            XFER_1: begin
                if (wr1_q) begin
                    sram_oe_n = 1'b1;
                    sram_we_n = 1'b0;
                    sram_d_oe = 1'b1;
                end
                next_state = ACCESS_2;
            end
            ACCESS_2: begin
                // Write address held one more cycle past the rising strobe
                if (!wr1_q) begin
                    sram_a = a2;
                end
                next_state = XFER_2;
            end
            XFER_2: begin
                sram_a     = a2;
                next_state = ACCESS_1;
            end
            default: begin
                next_state = ACCESS_1;
            end
        endcase
    end

    // Chip stays selected, some slot is always running
    assign sram_ce_n  = 1'b0;
    assign sram_d_out = din1;

    assign done1 = (state == XFER_1);
    assign done2 = (state == XFER_2);

    //////////////////////////////////////////////////////////////////////
    // Read data capture
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == XFER_1 && !wr1_q) begin
            dout1 <= sram_d_in;
        end
        if (state == XFER_2) begin
            dout2 <= sram_d_in;
        end
    end

    // Write strobe only after an address cycle with SRAM outputs off
    assert property (@(posedge clk) disable iff (!arst_n)
        !sram_we_n |-> sram_oe_n && $past(sram_oe_n))
        else $error("sram_we_n low without sram_oe_n high in and before it");

    // Never drive the data bus outside a write strobe
    assert property (@(posedge clk) disable iff (!arst_n)
        sram_d_oe |-> !sram_we_n)
        else $error("sram_d_oe high while sram_we_n is high");

endmodule

// File: hw/host_req_latch.sv
`timescale 1ns/1ps

module host_req_latch
    import sram_share_pkg::*;
#(
    parameter int ADDR_W = ADDR_W_DEF,
    parameter int DATA_W = DATA_W_DEF
) (
    input  logic              clk,
    input  logic              arst_n,
    // CPU side
    input  logic              cpu_req,
    input  logic              cpu_we,
    input  logic [ADDR_W-1:0] cpu_addr,
    input  logic [DATA_W-1:0] cpu_wdata,
    output logic              cpu_busy,
    output logic              cpu_ack,
    output logic [DATA_W-1:0] cpu_rdata,
    // Mux port 1
    output logic [ADDR_W-1:0] a1,
    output logic              we1_n,
    output logic [DATA_W-1:0] din1,
    input  logic              done1,
    input  logic [DATA_W-1:0] dout1
);

    logic              pending;
    logic              armed;
    logic              req_we;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;
    logic [DATA_W-1:0] rdata_q;

    // A done1 only counts once the request was seen in the ACCESS_1 before it
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending  <= 1'b0;
            armed    <= 1'b0;
            req_we   <= 1'b0;
            req_addr <= '0;
            cpu_ack  <= 1'b0;
        end else begin
            cpu_ack <= 1'b0;
            if (cpu_req && !cpu_busy) begin
                pending  <= 1'b1;
                armed    <= 1'b0;
                req_we   <= cpu_we;
                req_addr <= cpu_addr;
            end else if (pending) begin
                armed <= 1'b1;
                if (done1 && armed) begin
                    pending <= 1'b0;
                    armed   <= 1'b0;
                    cpu_ack <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_req && !cpu_busy) begin
            req_wdata <= cpu_wdata;
        end
        // Keep the last read byte on the bus after the ack
        if (cpu_ack && !req_we) begin
            rdata_q <= dout1;
        end
    end

    assign cpu_busy  = pending | cpu_ack;
    assign cpu_rdata = (cpu_ack && !req_we) ? dout1 : rdata_q;

    // Idle port reads harmlessly
    assign we1_n = ~(pending & req_we);
    assign a1    = req_addr;
    assign din1  = req_wdata;

    assert property (@(posedge clk) disable iff (!arst_n)
        cpu_req |-> !cpu_busy)
        else $error("cpu_req while cpu_busy");

endmodule

// File: hw/scan_reader.sv
`timescale 1ns/1ps

module scan_reader
    import sram_share_pkg::*;
#(
    parameter int ADDR_W   = ADDR_W_DEF,
    parameter int DATA_W   = DATA_W_DEF,
    parameter int SCAN_LEN = 16
) (
    input  logic              clk,
    input  logic              arst_n,
    // Control
    input  logic              scan_start,
    input  logic [ADDR_W-1:0] scan_base,
    // Mux port 2
    output logic [ADDR_W-1:0] a2,
    input  logic              done2,
    input  logic [DATA_W-1:0] dout2,
    // Pixel stream
    output logic [DATA_W-1:0] pix_data,
    output logic              pix_valid,
    output logic              scan_active
);

    localparam int CNT_W = $clog2(SCAN_LEN + 1);

    logic [ADDR_W-1:0] addr;
    logic [CNT_W-1:0]  remaining;
    logic              active;
    logic              armed;

    //////////////////////////////////////////////////////////////////////
    // Window walker
    //////////////////////////////////////////////////////////////////////

    // scan_start is ignored while a window is running
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            addr      <= '0;
            remaining <= '0;
            active    <= 1'b0;
            armed     <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= 1'b0;
            if (!active) begin
                if (scan_start) begin
                    addr      <= scan_base;
                    remaining <= CNT_W'(SCAN_LEN);
                    active    <= 1'b1;
                    armed     <= 1'b0;
                end
            end else begin
                // First done2 may belong to a slot that began before the load
                armed <= 1'b1;
                if (done2 && armed) begin
                    pix_valid <= 1'b1;
                    addr      <= addr + ADDR_W'(1);
                    remaining <= remaining - CNT_W'(1);
                    if (remaining == CNT_W'(1)) begin
                        active <= 1'b0;
                        armed  <= 1'b0;
                    end
                end
            end
        end
    end

    assign a2          = addr;
    assign scan_active = active;

    // dout2 is reloaded only at the next XFER_2, so it is stable under pix_valid
    assign pix_data = dout2;

    // Mid-window bytes arrive exactly one round apart
    assert property (@(posedge clk) disable iff (!arst_n)
        pix_valid && active |-> ##ROUND_CYCLES pix_valid)
        else $error("pix_valid not one round after the previous byte");

endmodule

// File: hw/sram_share_top.sv
`timescale 1ns/1ps

module sram_share_top
    import sram_share_pkg::*;
#(
    parameter int ADDR_W   = ADDR_W_DEF,
    parameter int DATA_W   = DATA_W_DEF,
    parameter int SCAN_LEN = 16
) (
    input  logic              clk,
    input  logic              arst_n,
    // Host CPU
    input  logic              cpu_req,
    input  logic              cpu_we,
    input  logic [ADDR_W-1:0] cpu_addr,
    input  logic [DATA_W-1:0] cpu_wdata,
    output logic              cpu_busy,
    output logic              cpu_ack,
    output logic [DATA_W-1:0] cpu_rdata,
    // Scan
    input  logic              scan_start,
    input  logic [ADDR_W-1:0] scan_base,
    output logic [DATA_W-1:0] pix_data,
    output logic              pix_valid,
    output logic              scan_active,
    // External SRAM
    output logic [ADDR_W-1:0] sram_a,
    input  logic [DATA_W-1:0] sram_d_in,
    output logic [DATA_W-1:0] sram_d_out,
    output logic              sram_d_oe,
    output logic              sram_ce_n,
    output logic              sram_oe_n,
    output logic              sram_we_n
);

    //////////////////////////////////////////////////////////////////////
    // Port wiring
    //////////////////////////////////////////////////////////////////////

    logic [ADDR_W-1:0] a1;
    logic              we1_n;
    logic [DATA_W-1:0] din1;
    logic [DATA_W-1:0] dout1;
    logic              done1;

    logic [ADDR_W-1:0] a2;
    logic [DATA_W-1:0] dout2;
    logic              done2;

    host_req_latch #(
        .ADDR_W (ADDR_W),
        .DATA_W (DATA_W)
    ) host_req_latch_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_req   (cpu_req),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_busy  (cpu_busy),
        .cpu_ack   (cpu_ack),
        .cpu_rdata (cpu_rdata),
        .a1        (a1),
        .we1_n     (we1_n),
        .din1      (din1),
        .done1     (done1),
        .dout1     (dout1)
    );

    scan_reader #(
        .ADDR_W   (ADDR_W),
        .DATA_W   (DATA_W),
        .SCAN_LEN (SCAN_LEN)
    ) scan_reader_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .scan_start  (scan_start),
        .scan_base   (scan_base),
        .a2          (a2),
        .done2       (done2),
        .dout2       (dout2),
        .pix_data    (pix_data),
        .pix_valid   (pix_valid),
        .scan_active (scan_active)
    );

    sram_port_mux #(
        .ADDR_W (ADDR_W),
        .DATA_W (DATA_W)
    ) sram_port_mux_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .a1         (a1),
        .we1_n      (we1_n),
        .din1       (din1),
        .dout1      (dout1),
        .done1      (done1),
        .a2         (a2),
        .dout2      (dout2),
        .done2      (done2),
        .sram_a     (sram_a),
        .sram_d_in  (sram_d_in),
        .sram_d_out (sram_d_out),
        .sram_d_oe  (sram_d_oe),
        .sram_ce_n  (sram_ce_n),
        .sram_oe_n  (sram_oe_n),
        .sram_we_n  (sram_we_n)
    );

endmodule

// File: test/sram_async_model.sv
`timescale 1ns/1ps

module sram_async_model #(
    parameter int ADDR_W = 10,
    parameter int DATA_W = 8
) (
    input  logic [ADDR_W-1:0] addr,
    input  logic              ce_n,
    input  logic              oe_n,
    input  logic              we_n,
    input  logic [DATA_W-1:0] wdata,
    input  logic              wdata_oe,
    output logic [DATA_W-1:0] rdata
);

    logic [DATA_W-1:0] mem [2**ADDR_W];

    // Power-up contents, every address bit shows up in the byte
    initial begin
        for (int i = 0; i < 2**ADDR_W; i++) begin
            mem[i] = DATA_W'(i ^ (i >> 2));
        end
    end

    // Write completes on the rising edge of the strobe
    always @(posedge we_n) begin
        if (!ce_n) begin
            mem[addr] = wdata;
        end
    end

    // Asynchronous read, bus pulled high when the SRAM does not drive it
    assign rdata = (!ce_n && !oe_n && !wdata_oe) ? mem[addr] : '1;

endmodule

// File: test/tb_sram_share.sv
`timescale 1ns/1ps

module tb_sram_share;

    localparam int ADDR_W   = 10;
    localparam int DATA_W   = 8;
    localparam int SCAN_LEN = 16;
    localparam int DEPTH    = 1024;
    localparam int ROUND    = 4;
    localparam int WAIT_MAX = 20;

    logic              clk;
    logic              arst_n;
    logic              cpu_req;
    logic              cpu_we;
    logic [ADDR_W-1:0] cpu_addr;
    logic [DATA_W-1:0] cpu_wdata;
    logic              cpu_busy;
    logic              cpu_ack;
    logic [DATA_W-1:0] cpu_rdata;
    logic              scan_start;
    logic [ADDR_W-1:0] scan_base;
    logic [DATA_W-1:0] pix_data;
    logic              pix_valid;
    logic              scan_active;
    logic [ADDR_W-1:0] sram_a;
    logic [DATA_W-1:0] sram_d_in;
    logic [DATA_W-1:0] sram_d_out;
    logic              sram_d_oe;
    logic              sram_ce_n;
    logic              sram_oe_n;
    logic              sram_we_n;

    // Expected SRAM contents
    logic [DATA_W-1:0] ref_mem [DEPTH];
    integer            seed           = 32'h1f07;
    int                cycle          = 0;
    int                last_pix_cycle = 0;
    logic              pix_run        = 1'b0;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    sram_share_top #(
        .ADDR_W   (ADDR_W),
        .DATA_W   (DATA_W),
        .SCAN_LEN (SCAN_LEN)
    ) sram_share_top_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .cpu_req     (cpu_req),
        .cpu_we      (cpu_we),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .cpu_busy    (cpu_busy),
        .cpu_ack     (cpu_ack),
        .cpu_rdata   (cpu_rdata),
        .scan_start  (scan_start),
        .scan_base   (scan_base),
        .pix_data    (pix_data),
        .pix_valid   (pix_valid),
        .scan_active (scan_active),
        .sram_a      (sram_a),
        .sram_d_in   (sram_d_in),
        .sram_d_out  (sram_d_out),
        .sram_d_oe   (sram_d_oe),
        .sram_ce_n   (sram_ce_n),
        .sram_oe_n   (sram_oe_n),
        .sram_we_n   (sram_we_n)
    );

    sram_async_model #(
        .ADDR_W (ADDR_W),
        .DATA_W (DATA_W)
    ) sram_async_model_inst (
        .addr     (sram_a),
        .ce_n     (sram_ce_n),
        .oe_n     (sram_oe_n),
        .we_n     (sram_we_n),
        .wdata    (sram_d_out),
        .wdata_oe (sram_d_oe),
        .rdata    (sram_d_in)
    );

    //////////////////////////////////////////////////////////////////////
    // Error reporting
    //////////////////////////////////////////////////////////////////////

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic flag_value(input string sig, input int got, input int exp);
        $display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, sig, got, exp);
        stop_run();
    endtask

    task automatic flag_event(input string what);
        $display("[FAIL] t=%0t %s", $time, what);
        stop_run();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Per-cycle pin and pixel timing monitor
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        cycle++;
        if (arst_n) begin
            if (!sram_we_n) begin
                assert (sram_oe_n && sram_d_oe)
                    else flag_event("sram_we_n low without sram_oe_n and sram_d_oe high");
            end
            if (pix_valid) begin
                if (pix_run) begin
                    assert (cycle - last_pix_cycle == ROUND)
                        else flag_value("pix_valid spacing", cycle - last_pix_cycle, ROUND);
                end
                last_pix_cycle = cycle;
                // Spacing restarts with the next window
                pix_run = scan_active;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_idle_pins();
        assert (sram_we_n) else flag_value("sram_we_n", int'(sram_we_n), 1);
        assert (!sram_d_oe) else flag_value("sram_d_oe", int'(sram_d_oe), 0);
        assert (!sram_ce_n) else flag_value("sram_ce_n", int'(sram_ce_n), 0);
        assert (!cpu_ack) else flag_value("cpu_ack", int'(cpu_ack), 0);
        assert (!cpu_busy) else flag_value("cpu_busy", int'(cpu_busy), 0);
        assert (!pix_valid) else flag_value("pix_valid", int'(pix_valid), 0);
        assert (!scan_active) else flag_value("scan_active", int'(scan_active), 0);
    endtask

    // One strobed request, busy checked on every cycle up to the ack
    task automatic cpu_access(input logic we, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata,
                              output logic [DATA_W-1:0] rdata);
        int n;
        n = 0;
        @(posedge clk);
        cpu_req   <= 1'b1;
        cpu_we    <= we;
        cpu_addr  <= addr;
        cpu_wdata <= wdata;
        @(posedge clk);
        cpu_req <= 1'b0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_MAX) begin
                flag_event("timeout waiting for cpu_ack");
            end
            assert (cpu_busy) else flag_value("cpu_busy", int'(cpu_busy), 1);
        end while (!cpu_ack);
        assert (n >= 3 && n <= 6)
            else flag_event($sformatf("cpu_ack came %0d cycles after cpu_req", n));
        rdata = cpu_rdata;
    endtask

    task automatic cpu_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] unused_rdata;
        cpu_access(1'b1, addr, data, unused_rdata);
        ref_mem[addr] = data;
    endtask

    task automatic expect_read(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] got;
        cpu_access(1'b0, addr, '0, got);
        assert (got == ref_mem[addr])
            else flag_value("cpu_rdata", int'(got), int'(ref_mem[addr]));
    endtask

    // Start a window and check every byte, then silence after it
    task automatic run_scan(input logic [ADDR_W-1:0] base);
        logic [ADDR_W-1:0] exp_addr;
        int                n;
        @(posedge clk);
        scan_start <= 1'b1;
        scan_base  <= base;
        @(posedge clk);
        scan_start <= 1'b0;
        for (int k = 0; k < SCAN_LEN; k++) begin
            exp_addr = ADDR_W'(int'(base) + k);
            n = 0;
            do begin
                @(negedge clk);
                n++;
                if (n > WAIT_MAX) begin
                    flag_event("timeout waiting for pix_valid");
                end
            end while (!pix_valid);
            assert (pix_data == ref_mem[exp_addr])
                else flag_value("pix_data", int'(pix_data), int'(ref_mem[exp_addr]));
            assert (scan_active == (k < SCAN_LEN - 1))
                else flag_value("scan_active", int'(scan_active), int'(k < SCAN_LEN - 1));
        end
        for (int i = 0; i < 2 * ROUND; i++) begin
            @(negedge clk);
            assert (!pix_valid) else flag_event("pix_valid after the last byte of the window");
            assert (!scan_active) else flag_value("scan_active", int'(scan_active), 0);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic reset_state();
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            check_idle_pins();
        end
        @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_idle_pins();
    endtask

    task automatic single_write_read();
        cpu_write(10'h155, 8'ha5);
        expect_read(10'h155);
    endtask

    task automatic random_transfers();
        logic [ADDR_W-1:0] addrs [32];
        logic [ADDR_W-1:0] tmp;
        int                j;
        for (int i = 0; i < 32; i++) begin
            addrs[i] = ADDR_W'($random(seed));
            cpu_write(addrs[i], DATA_W'($random(seed)));
        end
        // Fisher-Yates shuffle of the read order
        for (int i = 31; i > 0; i--) begin
            j = int'($unsigned($random(seed)) % (i + 1));
            tmp      = addrs[i];
            addrs[i] = addrs[j];
            addrs[j] = tmp;
        end
        for (int i = 0; i < 32; i++) begin
            expect_read(addrs[i]);
        end
    endtask

    task automatic full_scan_window();
        for (int a = 0; a < DEPTH; a++) begin
            cpu_write(ADDR_W'(a), DATA_W'($random(seed)));
        end
        run_scan(10'd1020);
    endtask

    // Addresses 300 and up stay clear of the window at 100
    task automatic cpu_traffic_outside();
        for (int i = 0; i < 8; i++) begin
            cpu_write(ADDR_W'(300 + i * 7), DATA_W'($random(seed)));
        end
        for (int i = 0; i < 8; i++) begin
            expect_read(ADDR_W'(300 + i * 7));
        end
    endtask

    task automatic overlapped_traffic();
        fork
            run_scan(10'd100);
            cpu_traffic_outside();
        join
    endtask

    initial begin
        arst_n     <= 1'b0;
        cpu_req    <= 1'b0;
        cpu_we     <= 1'b0;
        cpu_addr   <= '0;
        cpu_wdata  <= '0;
        scan_start <= 1'b0;
        scan_base  <= '0;
        for (int i = 0; i < DEPTH; i++) begin
            ref_mem[i] = DATA_W'(i ^ (i >> 2));
        end
        reset_state();
        single_write_read();
        random_transfers();
        full_scan_window();
        overlapped_traffic();
        $display("Test OK");
        $finish;
    end

endmodule

// File: files.f
hw/sram_share_pkg.sv
hw/sram_port_mux.sv
hw/host_req_latch.sv
hw/scan_reader.sv
hw/sram_share_top.sv
test/sram_async_model.sv
test/tb_sram_share.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_sram_share
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

# Pass or fail is decided by the log, not by the simulator exit code
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
